/* source/id_pkg.sv */
package id_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  exc_code_t;

    localparam exc_code_t EXC_NONE = 4'd0;
    localparam exc_code_t EXC_RI   = 4'd10;

    // major opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // special function field
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    // one-hot alu operation, bit positions
    typedef logic [11:0] alu_op_t;
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    typedef struct packed {
        logic [5:0] op;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] sa;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] index;
    } j_fmt_t;

    // one instruction word, three field layouts
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } inst_t;

    typedef struct packed {
        exc_code_t exc;
        inst_t     inst;
        word_t     pc;
    } fetch_bus_t;

    typedef struct packed {
        exc_code_t   exc;
        alu_op_t     alu_op;
        logic        src1_is_sa;
        logic        src1_is_pc;
        logic        src2_is_imm;
        logic        src2_is_uimm;
        logic        src2_is_8;
        logic        load_op;
        logic        gr_we;
        logic        mem_we;
        reg_addr_t   dest;
        logic [15:0] imm;
        word_t       rs_value;
        word_t       rt_value;
        word_t       pc;
    } decode_bus_t;

    // a later stage as seen from decode
    typedef struct packed {
        logic      valid;
        logic      gr_we;
        logic      res_from_mem;
        reg_addr_t dest;
        word_t     result;
    } fwd_src_t;

    typedef struct packed {
        logic      valid;
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } rf_write_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } br_bus_t;

    typedef struct packed {
        logic is_beq;
        logic is_bne;
        logic is_j;
        logic is_jal;
        logic is_jr;
        logic reads_rs;
        logic reads_rt;
    } ctrl_t;

endpackage

/* source/decode_latch.sv */
`timescale 1ns/1ps

module decode_latch (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  logic               fs_to_ds_valid,
    input  id_pkg::fetch_bus_t fs_to_ds_bus,
    input  logic               es_allowin,
    input  logic               ready_go,
    output logic               ds_allowin,
    output logic               ds_valid_out,
    output logic               ds_to_es_valid,
    output id_pkg::fetch_bus_t ds_bus
);

    logic ds_valid;

    assign ds_allowin     = !ds_valid || (ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ready_go;
    assign ds_valid_out   = ds_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (flush) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_bus <= fs_to_ds_bus;
        end
    end

    // outgoing valid only for an instruction taken in or already held
    a_out_needs_valid: assert property (
        @(posedge clk) disable iff (reset)
        ds_to_es_valid |-> $past(fs_to_ds_valid && ds_allowin) || $past(ds_valid_out)
    );

    // stalled instruction stays put until execute takes it
    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (reset)
        ds_valid_out && !es_allowin && !flush |=> ds_valid_out && $stable(ds_bus)
    );

endmodule

/* source/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
    input  id_pkg::inst_t     inst,
    input  id_pkg::exc_code_t exc_in,
    output id_pkg::alu_op_t   alu_op,
    output logic              src1_is_sa,
    output logic              src1_is_pc,
    output logic              src2_is_imm,
    output logic              src2_is_uimm,
    output logic              src2_is_8,
    output logic              load_op,
    output logic              gr_we,
    output logic              mem_we,
    output id_pkg::reg_addr_t dest,
    output id_pkg::exc_code_t exc_out,
    output id_pkg::ctrl_t     ctrl
);
    import id_pkg::*;

    logic is_special, sa_zero, rs_zero;
    logic inst_addu, inst_subu, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_xor, inst_nor;
    logic inst_sll, inst_srl, inst_sra, inst_jr;
    logic inst_addiu, inst_slti, inst_sltiu, inst_andi, inst_ori, inst_xori, inst_lui;
    logic inst_lw, inst_sw, inst_beq, inst_bne, inst_j, inst_jal;
    logic r_alu, shift, imm_alu, known;

    assign is_special = (inst.r.op == OP_SPECIAL);
    assign sa_zero    = (inst.r.sa == '0);
    assign rs_zero    = (inst.r.rs == '0);

    // register-register forms need sa zero, shifts need rs zero
    assign inst_addu  = is_special && inst.r.funct == FN_ADDU && sa_zero;
    assign inst_subu  = is_special && inst.r.funct == FN_SUBU && sa_zero;
    assign inst_slt   = is_special && inst.r.funct == FN_SLT  && sa_zero;
    assign inst_sltu  = is_special && inst.r.funct == FN_SLTU && sa_zero;
    assign inst_and   = is_special && inst.r.funct == FN_AND  && sa_zero;
    assign inst_or    = is_special && inst.r.funct == FN_OR   && sa_zero;
    assign inst_xor   = is_special && inst.r.funct == FN_XOR  && sa_zero;
    assign inst_nor   = is_special && inst.r.funct == FN_NOR  && sa_zero;
    assign inst_sll   = is_special && inst.r.funct == FN_SLL  && rs_zero;
    assign inst_srl   = is_special && inst.r.funct == FN_SRL  && rs_zero;
    assign inst_sra   = is_special && inst.r.funct == FN_SRA  && rs_zero;
    assign inst_jr    = is_special && inst.r.funct == FN_JR && inst.r.rt == '0
                        && inst.r.rd == '0 && sa_zero;

    assign inst_addiu = (inst.i.op == OP_ADDIU);
    assign inst_slti  = (inst.i.op == OP_SLTI);
    assign inst_sltiu = (inst.i.op == OP_SLTIU);
    assign inst_andi  = (inst.i.op == OP_ANDI);
    assign inst_ori   = (inst.i.op == OP_ORI);
    assign inst_xori  = (inst.i.op == OP_XORI);
    assign inst_lui   = (inst.i.op == OP_LUI) && (inst.i.rs == '0);
    assign inst_lw    = (inst.i.op == OP_LW);
    assign inst_sw    = (inst.i.op == OP_SW);
    assign inst_beq   = (inst.i.op == OP_BEQ);
    assign inst_bne   = (inst.i.op == OP_BNE);
    assign inst_j     = (inst.j.op == OP_J);
    assign inst_jal   = (inst.j.op == OP_JAL);

    assign r_alu   = inst_addu | inst_subu | inst_slt | inst_sltu
                   | inst_and | inst_or | inst_xor | inst_nor;
    assign shift   = inst_sll | inst_srl | inst_sra;
    assign imm_alu = inst_addiu | inst_slti | inst_sltiu | inst_andi
                   | inst_ori | inst_xori | inst_lui;
    assign known   = r_alu | shift | imm_alu | inst_lw | inst_sw
                   | inst_beq | inst_bne | inst_j | inst_jal | inst_jr;

    always_comb begin
        alu_op           = '0;
        // address add for loads, stores and the jal link
        alu_op[ALU_ADD]  = inst_addu | inst_addiu | inst_lw | inst_sw | inst_jal;
        alu_op[ALU_SUB]  = inst_subu;
        alu_op[ALU_SLT]  = inst_slt | inst_slti;
        alu_op[ALU_SLTU] = inst_sltu | inst_sltiu;
        alu_op[ALU_AND]  = inst_and | inst_andi;
        alu_op[ALU_NOR]  = inst_nor;
        alu_op[ALU_OR]   = inst_or | inst_ori;
        alu_op[ALU_XOR]  = inst_xor | inst_xori;
        alu_op[ALU_SLL]  = inst_sll;
        alu_op[ALU_SRL]  = inst_srl;
        alu_op[ALU_SRA]  = inst_sra;
        alu_op[ALU_LUI]  = inst_lui;
    end

    assign src1_is_sa   = shift;
    assign src1_is_pc   = inst_jal;
    assign src2_is_imm  = inst_addiu | inst_slti | inst_sltiu | inst_lui | inst_lw | inst_sw;
    assign src2_is_uimm = inst_andi | inst_ori | inst_xori;
    assign src2_is_8    = inst_jal;
    assign load_op      = inst_lw;
    assign mem_we       = inst_sw;
    assign gr_we        = r_alu | shift | imm_alu | inst_lw | inst_jal;

    assign dest = inst_jal   ? 5'd31 :
                  is_special ? inst.r.rd : inst.i.rt;

    assign ctrl.is_beq   = inst_beq;
    assign ctrl.is_bne   = inst_bne;
    assign ctrl.is_j     = inst_j;
    assign ctrl.is_jal   = inst_jal;
    assign ctrl.is_jr    = inst_jr;
    assign ctrl.reads_rs = r_alu | inst_jr | (imm_alu & ~inst_lui) | inst_lw | inst_sw
                         | inst_beq | inst_bne;
    assign ctrl.reads_rt = r_alu | shift | inst_sw | inst_beq | inst_bne;

    // a fetch-side exception wins over reserved instruction
    assign exc_out = (exc_in == EXC_NONE && !known) ? EXC_RI : exc_in;

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file #(
    parameter int REG_COUNT = 32
) (
    input  logic              clk,
    input  id_pkg::reg_addr_t raddr1,
    input  id_pkg::reg_addr_t raddr2,
    output id_pkg::word_t     rdata1,
    output id_pkg::word_t     rdata2,
    input  id_pkg::rf_write_t wr
);
    import id_pkg::*;

    word_t regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (wr.valid && wr.we && wr.addr != '0) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // r0 is hardwired, never read from storage
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* source/operand_bypass.sv */
`timescale 1ns/1ps

module operand_bypass (
    input  id_pkg::reg_addr_t rs,
    input  id_pkg::reg_addr_t rt,
    input  logic              reads_rs,
    input  logic              reads_rt,
    input  id_pkg::word_t     rf_rs,
    input  id_pkg::word_t     rf_rt,
    input  id_pkg::fwd_src_t  es_fwd,
    input  id_pkg::fwd_src_t  ms_fwd,
    input  id_pkg::rf_write_t ws_write,
    output id_pkg::word_t     rs_value,
    output id_pkg::word_t     rt_value,
    output logic              ready_go
);
    import id_pkg::*;

    logic es_load;
    logic load_use;

    // youngest producer first, r0 always from the file
    function automatic word_t select_operand(
        input reg_addr_t addr,
        input word_t     rf_value,
        input fwd_src_t  es,
        input fwd_src_t  ms,
        input rf_write_t ws
    );
        word_t value;
        if (addr == '0) begin
            value = rf_value;
        end else if (es.valid && es.gr_we && !es.res_from_mem && es.dest == addr) begin
            value = es.result;
        end else if (ms.valid && ms.gr_we && ms.dest == addr) begin
            value = ms.result;
        end else if (ws.valid && ws.we && ws.addr == addr) begin
            value = ws.data;
        end else begin
            value = rf_value;
        end
        return value;
    endfunction

    assign rs_value = select_operand(rs, rf_rs, es_fwd, ms_fwd, ws_write);
    assign rt_value = select_operand(rt, rf_rt, es_fwd, ms_fwd, ws_write);

    // load data not there yet while the load sits in execute
    assign es_load  = es_fwd.valid && es_fwd.gr_we && es_fwd.res_from_mem
                      && es_fwd.dest != '0;
    assign load_use = es_load && ((reads_rs && es_fwd.dest == rs)
                                  || (reads_rt && es_fwd.dest == rt));
    assign ready_go = !load_use;

    always_comb begin
        a_stall_cause: assert final (ready_go || (es_fwd.valid && es_fwd.res_from_mem
                                     && (es_fwd.dest == rs || es_fwd.dest == rt)))
            else $error("decode stalled with no load in execute");
    end

endmodule

/* source/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit (
    input  id_pkg::ctrl_t   ctrl,
    input  id_pkg::word_t   rs_value,
    input  id_pkg::word_t   rt_value,
    input  id_pkg::word_t   pc,
    input  logic [15:0]     imm,
    input  logic [25:0]     index,
    input  logic            stage_valid,
    output id_pkg::br_bus_t br_bus
);
    import id_pkg::*;

    word_t seq_pc;
    logic  rs_eq_rt;
    logic  cond;

    // delay-slot address
    assign seq_pc   = pc + 32'd4;
    assign rs_eq_rt = (rs_value == rt_value);

    assign cond = (ctrl.is_beq && rs_eq_rt)
                || (ctrl.is_bne && !rs_eq_rt)
                || ctrl.is_j || ctrl.is_jal || ctrl.is_jr;

    assign br_bus.taken = cond && stage_valid;

    assign br_bus.target = (ctrl.is_beq || ctrl.is_bne) ?
                               seq_pc + {{14{imm[15]}}, imm, 2'b00} :
                           ctrl.is_jr ? rs_value :
                           {seq_pc[31:28], index, 2'b00};

endmodule

/* source/id_stage.sv */
`timescale 1ns/1ps

module id_stage #(
    parameter int REG_COUNT = 32
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               fs_to_ds_valid,
    input  id_pkg::fetch_bus_t fs_to_ds_bus,
    input  logic               es_allowin,
    input  id_pkg::fwd_src_t   es_fwd,
    input  id_pkg::fwd_src_t   ms_fwd,
    input  id_pkg::rf_write_t  ws_write,
    input  logic               flush,
    output logic               ds_allowin,
    output logic               ds_to_es_valid,
    output id_pkg::decode_bus_t ds_to_es_bus,
    output id_pkg::br_bus_t    br_bus
);
    import id_pkg::*;

    fetch_bus_t ds_bus;
    logic       ready_go;
    ctrl_t      ctrl;
    word_t      rf_rdata1;
    word_t      rf_rdata2;
    word_t      rs_value;
    word_t      rt_value;
    alu_op_t    alu_op;
    logic       src1_is_sa;
    logic       src1_is_pc;
    logic       src2_is_imm;
    logic       src2_is_uimm;
    logic       src2_is_8;
    logic       load_op;
    logic       gr_we;
    logic       mem_we;
    reg_addr_t  dest;
    exc_code_t  ds_exc;

    decode_latch i_latch (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .es_allowin     (es_allowin),
        .ready_go       (ready_go),
        .ds_allowin     (ds_allowin),
        // raw valid bit is only checked inside the latch
        .ds_valid_out   (),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_bus         (ds_bus)
    );

    inst_decoder i_decoder (
        .inst         (ds_bus.inst),
        .exc_in       (ds_bus.exc),
        .alu_op       (alu_op),
        .src1_is_sa   (src1_is_sa),
        .src1_is_pc   (src1_is_pc),
        .src2_is_imm  (src2_is_imm),
        .src2_is_uimm (src2_is_uimm),
        .src2_is_8    (src2_is_8),
        .load_op      (load_op),
        .gr_we        (gr_we),
        .mem_we       (mem_we),
        .dest         (dest),
        .exc_out      (ds_exc),
        .ctrl         (ctrl)
    );

    reg_file #(
        .REG_COUNT (REG_COUNT)
    ) i_reg_file (
        .clk    (clk),
        .raddr1 (ds_bus.inst.r.rs),
        .raddr2 (ds_bus.inst.r.rt),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (ws_write)
    );

    operand_bypass i_bypass (
        .rs       (ds_bus.inst.r.rs),
        .rt       (ds_bus.inst.r.rt),
        .reads_rs (ctrl.reads_rs),
        .reads_rt (ctrl.reads_rt),
        .rf_rs    (rf_rdata1),
        .rf_rt    (rf_rdata2),
        .es_fwd   (es_fwd),
        .ms_fwd   (ms_fwd),
        .ws_write (ws_write),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .ready_go (ready_go)
    );

    branch_unit i_branch (
        .ctrl        (ctrl),
        .rs_value    (rs_value),
        .rt_value    (rt_value),
        .pc          (ds_bus.pc),
        .imm         (ds_bus.inst.i.imm),
        .index       (ds_bus.inst.j.index),
        .stage_valid (ds_to_es_valid),
        .br_bus      (br_bus)
    );

    always_comb begin
        ds_to_es_bus.exc          = ds_exc;
        ds_to_es_bus.alu_op       = alu_op;
        ds_to_es_bus.src1_is_sa   = src1_is_sa;
        ds_to_es_bus.src1_is_pc   = src1_is_pc;
        ds_to_es_bus.src2_is_imm  = src2_is_imm;
        ds_to_es_bus.src2_is_uimm = src2_is_uimm;
        ds_to_es_bus.src2_is_8    = src2_is_8;
        ds_to_es_bus.load_op      = load_op;
        ds_to_es_bus.gr_we        = gr_we;
        ds_to_es_bus.mem_we       = mem_we;
        ds_to_es_bus.dest         = dest;
        ds_to_es_bus.imm          = ds_bus.inst.i.imm;
        ds_to_es_bus.rs_value     = rs_value;
        ds_to_es_bus.rt_value     = rt_value;
        ds_to_es_bus.pc           = ds_bus.pc;
    end

endmodule

/* dv/id_stage_tb.sv */
`timescale 1ns/1ps

module id_stage_tb;
    import id_pkg::*;

    // well above the cycles the tests need
    localparam int CYCLE_LIMIT = 400;
    localparam logic [5:0] R_FUNCTS [11] = '{FN_ADDU, FN_SUBU, FN_SLT, FN_SLTU, FN_AND,
        FN_OR, FN_XOR, FN_NOR, FN_SLL, FN_SRL, FN_SRA};
    localparam logic [5:0] I_OPS [9] = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI,
        OP_XORI, OP_LUI, OP_LW, OP_SW};

    logic        clk;
    logic        reset;
    logic        fs_to_ds_valid;
    fetch_bus_t  fs_to_ds_bus;
    logic        es_allowin;
    fwd_src_t    es_fwd;
    fwd_src_t    ms_fwd;
    rf_write_t   ws_write;
    logic        flush;
    logic        ds_allowin;
    logic        ds_to_es_valid;
    decode_bus_t ds_to_es_bus;
    br_bus_t     br_bus;

    word_t  regs_model [32];
    integer seed = 32'h6cb0_2334;
    int     cycles = 0;

    id_stage #(.REG_COUNT(32)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: test did not finish within %0d cycles", CYCLE_LIMIT);
            stop_with_failure();
        end
    end

    task automatic stop_with_failure();
        $display("Done: errors found");
        $fatal(1, "run stopped");
    endtask

    task automatic compare_decode(string name, decode_bus_t got, decode_bus_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic compare_branch(string name, br_bus_t got, br_bus_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic compare_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    function automatic inst_t r_inst(logic [5:0] fn, reg_addr_t rs, reg_addr_t rt,
                                     reg_addr_t rd, logic [4:0] sa);
        inst_t w;
        w.r = '{op: OP_SPECIAL, rs: rs, rt: rt, rd: rd, sa: sa, funct: fn};
        return w;
    endfunction

    function automatic inst_t i_inst(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                     logic [15:0] imm);
        inst_t w;
        w.i = '{op: op, rs: rs, rt: rt, imm: imm};
        return w;
    endfunction

    function automatic inst_t j_inst(logic [5:0] op, logic [25:0] index);
        inst_t w;
        w.j = '{op: op, index: index};
        return w;
    endfunction

    function automatic reg_addr_t rand_reg();
        return reg_addr_t'($random(seed));
    endfunction

    function automatic word_t rand_pc();
        return word_t'($random(seed)) & 32'hffff_fffc;
    endfunction

    // expected decode from the instruction encoding rules
    function automatic decode_bus_t expect_decode(inst_t inst, exc_code_t exc, word_t pc);
        decode_bus_t e;
        logic known;
        e = '0;
        known = 1'b1;
        e.exc = exc;
        e.imm = inst.i.imm;
        e.pc = pc;
        e.rs_value = regs_model[inst.r.rs];
        e.rt_value = regs_model[inst.r.rt];
        e.dest = inst.i.rt;
        case (inst.r.op)
            OP_SPECIAL: begin
                e.dest = inst.r.rd;
                e.gr_we = 1'b1;
                case (inst.r.funct)
                    FN_ADDU: e.alu_op[ALU_ADD] = 1'b1;
                    FN_SUBU: e.alu_op[ALU_SUB] = 1'b1;
                    FN_SLT:  e.alu_op[ALU_SLT] = 1'b1;
                    FN_SLTU: e.alu_op[ALU_SLTU] = 1'b1;
                    FN_AND:  e.alu_op[ALU_AND] = 1'b1;
                    FN_OR:   e.alu_op[ALU_OR] = 1'b1;
                    FN_XOR:  e.alu_op[ALU_XOR] = 1'b1;
                    FN_NOR:  e.alu_op[ALU_NOR] = 1'b1;
                    FN_SLL:  {e.alu_op[ALU_SLL], e.src1_is_sa} = 2'b11;
                    FN_SRL:  {e.alu_op[ALU_SRL], e.src1_is_sa} = 2'b11;
                    FN_SRA:  {e.alu_op[ALU_SRA], e.src1_is_sa} = 2'b11;
                    FN_JR:   e.gr_we = 1'b0;
                    default: {known, e.gr_we} = 2'b00;
                endcase
            end
            OP_ADDIU: {e.alu_op[ALU_ADD], e.src2_is_imm, e.gr_we} = 3'b111;
            OP_SLTI:  {e.alu_op[ALU_SLT], e.src2_is_imm, e.gr_we} = 3'b111;
            OP_SLTIU: {e.alu_op[ALU_SLTU], e.src2_is_imm, e.gr_we} = 3'b111;
            OP_ANDI:  {e.alu_op[ALU_AND], e.src2_is_uimm, e.gr_we} = 3'b111;
            OP_ORI:   {e.alu_op[ALU_OR], e.src2_is_uimm, e.gr_we} = 3'b111;
            OP_XORI:  {e.alu_op[ALU_XOR], e.src2_is_uimm, e.gr_we} = 3'b111;
            OP_LUI:   {e.alu_op[ALU_LUI], e.src2_is_imm, e.gr_we} = 3'b111;
            OP_LW:    {e.alu_op[ALU_ADD], e.src2_is_imm, e.load_op, e.gr_we} = 4'b1111;
            OP_SW:    {e.alu_op[ALU_ADD], e.src2_is_imm, e.mem_we} = 3'b111;
            OP_BEQ, OP_BNE, OP_J: ;
            OP_JAL: begin
                {e.alu_op[ALU_ADD], e.src1_is_pc, e.src2_is_8, e.gr_we} = 4'b1111;
                e.dest = 5'd31;
            end
            default: known = 1'b0;
        endcase
        if (!known && exc == EXC_NONE) begin
            e.exc = EXC_RI;
        end
        return e;
    endfunction

    function automatic logic is_branch(inst_t inst);
        return inst.r.op inside {OP_BEQ, OP_BNE, OP_J, OP_JAL}
            || (inst.r.op == OP_SPECIAL && inst.r.funct == FN_JR);
    endfunction

    function automatic br_bus_t expect_branch(inst_t inst, word_t pc);
        br_bus_t b;
        word_t rs_v;
        word_t rt_v;
        word_t seq;
        rs_v = regs_model[inst.r.rs];
        rt_v = regs_model[inst.r.rt];
        seq = pc + 32'd4;
        b.taken = 1'b1;
        b.target = {seq[31:28], inst.j.index, 2'b00};
        if (inst.r.op == OP_BEQ || inst.r.op == OP_BNE) begin
            b.target = seq + {{14{inst.i.imm[15]}}, inst.i.imm, 2'b00};
            b.taken = (rs_v == rt_v) ^ (inst.r.op == OP_BNE);
        end else if (inst.r.op == OP_SPECIAL) begin
            b.target = rs_v;
        end
        return b;
    endfunction

    task automatic write_reg(reg_addr_t addr, word_t data);
        ws_write = '{valid: 1'b1, we: 1'b1, addr: addr, data: data};
        @(posedge clk);
        #1;
        ws_write = '0;
        if (addr != '0) begin
            regs_model[addr] = data;
        end
    endtask

    task automatic issue(inst_t inst, exc_code_t exc, word_t pc);
        fs_to_ds_bus = '{exc: exc, inst: inst, pc: pc};
        fs_to_ds_valid = 1'b1;
        while (!ds_allowin) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        fs_to_ds_valid = 1'b0;
    endtask

    task automatic check_one(inst_t inst, exc_code_t exc);
        word_t pc;
        pc = rand_pc();
        issue(inst, exc, pc);
        compare_bit("ds_to_es_valid", ds_to_es_valid, 1'b1);
        compare_decode("ds_to_es_bus", ds_to_es_bus, expect_decode(inst, exc, pc));
        if (is_branch(inst)) begin
            compare_branch("br_bus", br_bus, expect_branch(inst, pc));
        end else begin
            compare_bit("br_bus.taken", br_bus.taken, 1'b0);
        end
    endtask

    task automatic test_decode();
        logic shift;
        for (int k = 0; k < 11; k++) begin
            shift = R_FUNCTS[k] inside {FN_SLL, FN_SRL, FN_SRA};
            check_one(r_inst(R_FUNCTS[k], shift ? 5'd0 : rand_reg(), rand_reg(), rand_reg(),
                             shift ? rand_reg() : 5'd0), EXC_NONE);
        end
        for (int k = 0; k < 9; k++) begin
            check_one(i_inst(I_OPS[k], I_OPS[k] == OP_LUI ? 5'd0 : rand_reg(), rand_reg(),
                             16'($random(seed))), EXC_NONE);
        end
    endtask

    task automatic test_bypass();
        inst_t inst;
        decode_bus_t exp;
        word_t pc;
        pc = rand_pc();
        inst = r_inst(FN_ADDU, 5'd5, 5'd6, 5'd7, 5'd0);
        issue(inst, EXC_NONE, pc);
        exp = expect_decode(inst, EXC_NONE, pc);
        es_fwd = '{valid: 1'b1, gr_we: 1'b1, res_from_mem: 1'b0, dest: 5'd5, result: 32'haaaa_0001};
        ms_fwd = '{valid: 1'b1, gr_we: 1'b1, res_from_mem: 1'b0, dest: 5'd5, result: 32'hbbbb_0002};
        ws_write = '{valid: 1'b1, we: 1'b1, addr: 5'd5, data: 32'hcccc_0003};
        #5;
        exp.rs_value = 32'haaaa_0001;
        compare_decode("ds_to_es_bus.rs_value from es", ds_to_es_bus, exp);
        es_fwd = '0;
        #5;
        exp.rs_value = 32'hbbbb_0002;
        compare_decode("ds_to_es_bus.rs_value from ms", ds_to_es_bus, exp);
        ms_fwd = '0;
        #5;
        exp.rs_value = 32'hcccc_0003;
        compare_decode("ds_to_es_bus.rs_value from ws", ds_to_es_bus, exp);
        ws_write = '0;
        #5;
        exp.rs_value = regs_model[5];
        compare_decode("ds_to_es_bus.rs_value from file", ds_to_es_bus, exp);
        // register 0 ignores every forwarding source
        inst = r_inst(FN_ADDU, 5'd0, 5'd0, 5'd7, 5'd0);
        issue(inst, EXC_NONE, pc);
        es_fwd = '{valid: 1'b1, gr_we: 1'b1, res_from_mem: 1'b0, dest: 5'd0, result: 32'h1};
        ms_fwd = '{valid: 1'b1, gr_we: 1'b1, res_from_mem: 1'b0, dest: 5'd0, result: 32'h2};
        ws_write = '{valid: 1'b1, we: 1'b1, addr: 5'd0, data: 32'h3};
        #5;
        compare_decode("ds_to_es_bus r0", ds_to_es_bus, expect_decode(inst, EXC_NONE, pc));
        es_fwd = '0;
        ms_fwd = '0;
        ws_write = '0;
    endtask

    task automatic test_stall();
        inst_t inst;
        word_t pc;
        for (int k = 0; k < 2; k++) begin
            pc = rand_pc();
            inst = r_inst(FN_SUBU, 5'd7, 5'd8, 5'd9, 5'd0);
            issue(inst, EXC_NONE, pc);
            // load in execute writes a register the instruction reads
            es_fwd = '{valid: 1'b1, gr_we: 1'b1, res_from_mem: 1'b1,
                       dest: (k == 0) ? 5'd7 : 5'd8, result: word_t'($random(seed))};
            #1;
            compare_bit("ds_to_es_valid", ds_to_es_valid, 1'b0);
            compare_bit("ds_allowin", ds_allowin, 1'b0);
            @(posedge clk);
            #1;
            compare_bit("ds_to_es_valid", ds_to_es_valid, 1'b0);
            compare_bit("ds_allowin", ds_allowin, 1'b0);
            es_fwd = '0;
            #1;
            compare_bit("ds_to_es_valid", ds_to_es_valid, 1'b1);
            compare_bit("ds_allowin", ds_allowin, 1'b1);
            compare_decode("ds_to_es_bus", ds_to_es_bus, expect_decode(inst, EXC_NONE, pc));
        end
    endtask

    task automatic test_branches();
        word_t v;
        v = word_t'($random(seed));
        write_reg(5'd3, v);
        write_reg(5'd4, v);
        write_reg(5'd2, v ^ 32'h1);
        check_one(i_inst(OP_BEQ, 5'd3, 5'd4, 16'($random(seed))), EXC_NONE);
        check_one(i_inst(OP_BEQ, 5'd3, 5'd2, 16'($random(seed))), EXC_NONE);
        check_one(i_inst(OP_BNE, 5'd3, 5'd2, 16'($random(seed))), EXC_NONE);
        check_one(i_inst(OP_BNE, 5'd3, 5'd4, 16'($random(seed))), EXC_NONE);
        check_one(j_inst(OP_J, 26'($random(seed))), EXC_NONE);
        check_one(j_inst(OP_JAL, 26'($random(seed))), EXC_NONE);
        check_one(r_inst(FN_JR, 5'd2, 5'd0, 5'd0, 5'd0), EXC_NONE);
    endtask

    task automatic test_exceptions();
        check_one(i_inst(6'h3f, rand_reg(), rand_reg(), 16'h1234), EXC_NONE);
        check_one(r_inst(FN_ADDU, rand_reg(), rand_reg(), rand_reg(), 5'd0), 4'd4);
        check_one(i_inst(6'h3f, rand_reg(), rand_reg(), 16'h4321), 4'd4);
    endtask

    task automatic test_backpressure_flush();
        inst_t inst;
        word_t pc;
        pc = rand_pc();
        inst = i_inst(OP_ORI, 5'd3, 5'd11, 16'h00ff);
        issue(inst, EXC_NONE, pc);
        es_allowin = 1'b0;
        #1;
        compare_bit("ds_to_es_valid", ds_to_es_valid, 1'b1);
        compare_bit("ds_allowin", ds_allowin, 1'b0);
        // a new fetch must not overwrite the held instruction
        fs_to_ds_bus = '{exc: EXC_NONE, inst: r_inst(FN_OR, 5'd1, 5'd2, 5'd3, 5'd0), pc: 0};
        fs_to_ds_valid = 1'b1;
        @(posedge clk);
        #1;
        fs_to_ds_valid = 1'b0;
        compare_bit("ds_allowin", ds_allowin, 1'b0);
        compare_decode("ds_to_es_bus", ds_to_es_bus, expect_decode(inst, EXC_NONE, pc));
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        compare_bit("ds_to_es_valid", ds_to_es_valid, 1'b0);
        compare_bit("ds_allowin", ds_allowin, 1'b1);
        es_allowin = 1'b1;
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        compare_bit("ds_allowin", ds_allowin, 1'b1);
        compare_bit("ds_to_es_valid", ds_to_es_valid, 1'b0);
        compare_bit("br_bus.taken", br_bus.taken, 1'b0);
    endtask

    task automatic test_reset();
        es_allowin = 1'b0;
        issue(j_inst(OP_J, 26'h15), EXC_NONE, rand_pc());
        compare_bit("br_bus.taken", br_bus.taken, 1'b1);
        apply_reset();
        es_allowin = 1'b1;
    endtask

    initial begin
        fs_to_ds_valid = 1'b0;
        fs_to_ds_bus = '0;
        es_allowin = 1'b1;
        es_fwd = '0;
        ms_fwd = '0;
        ws_write = '0;
        flush = 1'b0;
        regs_model[0] = '0;
        apply_reset();
        for (int k = 1; k < 32; k++) begin
            write_reg(reg_addr_t'(k), word_t'($random(seed)));
        end
        test_decode();
        test_bypass();
        test_stall();
        test_branches();
        test_exceptions();
        test_backpressure_flush();
        test_reset();
        $display("Done: no errors");
        $finish;
    end

endmodule

/* filelist.f */
source/id_pkg.sv
source/decode_latch.sv
source/inst_decoder.sv
source/reg_file.sv
source/operand_bypass.sv
source/branch_unit.sv
source/id_stage.sv
dv/id_stage_tb.sv
